// ==== test/scara_golden.txt ====
// cmd_word fast stop_delay extra_word exp_status exp_steps1 exp_steps2 exp_rejects
// All hex; stop_delay 0 means no stop, extra_word is sent 4 cycles into the move
800C0051 1 00 00000000 0 05 03 00
800C0051 0 00 00000000 0 05 03 00
001E00C1 1 00 00000000 0 0C 07 00
0009F031 0 00 00000000 0 03 02 00
80100001 1 00 00000000 0 00 04 00
00000001 0 00 00000000 0 00 00 00
802A0141 0 64 00000000 1 00 00 00
00140301 1 50 00000000 1 00 00 00
00180081 0 00 83FE0FF1 0 08 06 01
00080021 1 00 00000000 0 02 02 00
00000000 0 00 00000000 0 00 00 00
0004005F 1 00 00000000 0 00 00 00
00000002 0 00 00000000 0 00 00 00
80060011 0 00 00000000 0 01 01 00
82000FF1 1 00 00000000 0 FF 80 00

// ==== scara_motion_top.f ====
+incdir+include
hdl/scara_pkg.sv
hdl/command_decoder.sv
hdl/stepper_joint.sv
hdl/motion_status.sv
hdl/scara_motion_top.sv
test/tb_scara_motion.sv

// ==== Bender.yml ====
package:
  name: scara_motion

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/scara_pkg.sv
      - hdl/command_decoder.sv
      - hdl/stepper_joint.sv
      - hdl/motion_status.sv
      - hdl/scara_motion_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_scara_motion.sv

// ==== test/tb_scara_motion.sv ====
// Testbench for scara_motion_top with golden vectors, command driver, pulse monitor and checks
`default_nettype none
`timescale 1ns/1ps

`include "scara_defs.svh"

module tb_scara_motion;

	localparam int MAX_TESTS = 32;
	localparam int COLS = 8;
	// Cycle in a move where the extra word is sent
	localparam int EXTRA_AT = 4;
	// Window in which an idle command must stay silent
	localparam int IDLE_WAIT = 24;

	logic                     CLOCK_50;
	logic                     rst;
	logic                     cmd_valid;
	scara_pkg::command_t      cmd_word;
	logic                     fast;
	logic                     step1;
	logic                     dir1;
	logic                     step2;
	logic                     dir2;
	logic                     rsp_valid;
	scara_pkg::response_t     rsp;

	logic [31:0] gold [0:MAX_TESTS*COLS-1];
	int          num_tests;
	int          errors;
	int          pulses1;
	int          pulses2;
	int          rsp_seen;
	int          cyc_cnt;
	int          last_rise1;
	int          last_rise2;
	logic        exp_dir1;
	logic        exp_dir2;
	logic        step1_prev;
	logic        step2_prev;
	logic [31:0] lcg_state;

	scara_motion_top dut0 (
		.CLOCK_50(CLOCK_50), .rst(rst), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
		.fast(fast), .step1(step1), .dir1(dir1), .step2(step2), .dir2(dir2),
		.rsp_valid(rsp_valid), .rsp(rsp)
	);

	// 40 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_response(input string name, input scara_pkg::response_t got,
		input scara_pkg::response_t exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input scara_pkg::status_e got,
		input scara_pkg::status_e exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_count(input string name, input logic [`SCARA_STEP_W-1:0] got,
		input logic [`SCARA_STEP_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Full step period in clock cycles at the current speed
	function automatic logic [`SCARA_STEP_W-1:0] step_period();
		return fast ? `SCARA_STEP_W'(2 * `SCARA_HALF_FAST)
			: `SCARA_STEP_W'(2 * `SCARA_HALF_SLOW);
	endfunction

	// Next rising clock edge plus the drive delay
	task automatic tick();
		@(posedge CLOCK_50);
		#2;
	endtask

	// Pulse counting, period and dir checks on the falling edge where outputs are stable
	always @(negedge CLOCK_50) begin
		cyc_cnt++;
		if (step1 && !step1_prev) begin
			// Later rising edges of a move come one full step period apart
			if (pulses1 > 0)
				check_count("step1 period", `SCARA_STEP_W'(cyc_cnt - last_rise1),
					step_period());
			pulses1++;
			last_rise1 = cyc_cnt;
			check_bit("dir1", dir1, exp_dir1);
		end
		if (step2 && !step2_prev) begin
			if (pulses2 > 0)
				check_count("step2 period", `SCARA_STEP_W'(cyc_cnt - last_rise2),
					step_period());
			pulses2++;
			last_rise2 = cyc_cnt;
			check_bit("dir2", dir2, exp_dir2);
		end
		if (rsp_valid)
			rsp_seen++;
		step1_prev = step1;
		step2_prev = step2;
	end

	// ============================================================
	// One golden line
	// ============================================================
	task automatic run_test(input int t);
		scara_pkg::command_t  cmd;
		scara_pkg::command_t  extra;
		scara_pkg::command_t  stop_cmd;
		scara_pkg::response_t got;
		scara_pkg::response_t exp;
		logic [31:0]          raw;
		int                   stop_at;
		int                   cyc;
		int                   seen_before;
		bit                   done;
		raw = gold[t*COLS];
		cmd = raw;
		stop_at = gold[t*COLS+2];
		extra = gold[t*COLS+3];
		exp.status = scara_pkg::status_e'(gold[t*COLS+4][1:0]);
		exp.steps1 = gold[t*COLS+5][`SCARA_STEP_W-1:0];
		exp.steps2 = gold[t*COLS+6][`SCARA_STEP_W-1:0];
		exp.rejects = gold[t*COLS+7][`SCARA_REJ_W-1:0];
		exp.spare = '0;
		stop_cmd = '0;
		stop_cmd.op = scara_pkg::OP_STOP;
		pulses1 = 0;
		pulses2 = 0;
		seen_before = rsp_seen;
		// x field in word bits 17:4, y in 31:18, field bit 13 is direction
		exp_dir1 = raw[17];
		exp_dir2 = raw[31];
		fast = gold[t*COLS+1][0];
		cmd_word = cmd;
		cmd_valid = 1'b1;
		if (cmd.op != scara_pkg::OP_MOVE) begin
			tick();
			cmd_valid = 1'b0;
			repeat (IDLE_WAIT) tick();
			check_count("step1 pulses", pulses1[`SCARA_STEP_W-1:0], '0);
			check_count("step2 pulses", pulses2[`SCARA_STEP_W-1:0], '0);
			if (rsp_seen != seen_before) begin
				errors++;
				$display("Test %0d: a response came after a command that starts no move", t);
			end
		end else begin
			cyc = 0;
			done = 0;
			while (!done) begin
				@(negedge CLOCK_50);
				if (rsp_valid) begin
					done = 1;
					got = rsp;
				end else begin
					tick();
					cmd_valid = 1'b0;
					cyc++;
					if (cyc == EXTRA_AT && extra != '0) begin
						cmd_word = extra;
						cmd_valid = 1'b1;
					end
					if (cyc == stop_at) begin
						cmd_word = stop_cmd;
						cmd_valid = 1'b1;
					end
				end
			end
			tick();
			cmd_valid = 1'b0;
			if (exp.status == scara_pkg::ST_DONE) begin
				check_response("rsp", got, exp);
				check_count("step1 pulses", pulses1[`SCARA_STEP_W-1:0], exp.steps1);
				check_count("step2 pulses", pulses2[`SCARA_STEP_W-1:0], exp.steps2);
			end else begin
				// Stopped move reports what was actually stepped
				check_status("rsp.status", got.status, exp.status);
				check_count("rsp.steps1", got.steps1, pulses1[`SCARA_STEP_W-1:0]);
				check_count("rsp.steps2", got.steps2, pulses2[`SCARA_STEP_W-1:0]);
				check_count("rsp.rejects", got.rejects, exp.rejects);
				// Requested counts sit in word bits 11:4 and 25:18
				if (got.steps1 > raw[11:4] || got.steps2 > raw[25:18]) begin
					errors++;
					$display("Test %0d: a stopped joint reported more steps than requested", t);
				end
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_word = '0;
		fast = 1'b0;
		errors = 0;
		num_tests = 0;
		rsp_seen = 0;
		pulses1 = 0;
		pulses2 = 0;
		cyc_cnt = 0;
		last_rise1 = 0;
		last_rise2 = 0;
		exp_dir1 = 1'b0;
		exp_dir2 = 1'b0;
		step1_prev = 1'b0;
		step2_prev = 1'b0;
		lcg_state = 32'h5eba4afd;
		$readmemh("test/scara_golden.txt", gold);
		while (num_tests < MAX_TESTS && !$isunknown(gold[num_tests*COLS]))
			num_tests++;
		if (num_tests == 0) begin
			errors++;
			$display("No test vectors could be read from the golden file");
		end
		repeat (16) tick();
		rst = 1'b0;
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
			// Random idle gap between tests
			lcg_state = lcg_next(lcg_state);
			repeat (2 + lcg_state[18:16]) tick();
		end
		$display("Tests run: %0d, errors: %0d", num_tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog sized for the longest possible slow move per test
	initial begin
		longint limit;
		wait (num_tests > 0);
		limit = num_tests * (2 * 255 * 2 * `SCARA_HALF_SLOW + 64) + 16;
		repeat (limit) @(posedge CLOCK_50);
		$display("Watchdog expired after %0d cycles, a response never arrived", limit);
		$display("Tests run: %0d, errors: %0d", num_tests, errors + 1);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/scara_motion_top.sv ====
// Top level: command decoder, two stepper joints and the status block
`default_nettype none
`timescale 1ns/1ps

`include "scara_defs.svh"

module scara_motion_top (
	input  wire                   CLOCK_50,
	input  wire                   rst,
	input  logic                  cmd_valid,
	input  scara_pkg::command_t   cmd_word,
	input  logic                  fast,
	output logic                  step1,
	output logic                  dir1,
	output logic                  step2,
	output logic                  dir2,
	output logic                  rsp_valid,
	output scara_pkg::response_t  rsp
);

	// ============================================================
	// Internal wires
	// ============================================================
	logic                     move_active;
	logic                     move_strobe;
	logic                     stop_strobe;
	logic                     reject_strobe;
	scara_pkg::joint_req_t    req1;
	scara_pkg::joint_req_t    req2;
	logic                     busy1;
	logic                     busy2;
	logic [`SCARA_STEP_W-1:0] steps1;
	logic [`SCARA_STEP_W-1:0] steps2;

	command_decoder u_dec (
		.CLOCK_50(CLOCK_50), .rst(rst),
		.cmd_valid(cmd_valid), .cmd_word(cmd_word), .move_active(move_active),
		.move_strobe(move_strobe), .stop_strobe(stop_strobe),
		.reject_strobe(reject_strobe), .req1(req1), .req2(req2)
	);

	// Joint 1 from the x field
	stepper_joint u_joint1 (
		.CLOCK_50(CLOCK_50), .rst(rst), .load(move_strobe), .abort(stop_strobe),
		.req(req1), .fast(fast), .step(step1), .dir(dir1), .busy(busy1),
		.steps_taken(steps1)
	);

	// Joint 2 from the y field
	stepper_joint u_joint2 (
		.CLOCK_50(CLOCK_50), .rst(rst), .load(move_strobe), .abort(stop_strobe),
		.req(req2), .fast(fast), .step(step2), .dir(dir2), .busy(busy2),
		.steps_taken(steps2)
	);

	motion_status u_status (
		.CLOCK_50(CLOCK_50), .rst(rst),
		.move_strobe(move_strobe), .stop_strobe(stop_strobe),
		.reject_strobe(reject_strobe), .busy1(busy1), .busy2(busy2),
		.steps1(steps1), .steps2(steps2), .move_active(move_active),
		.rsp_valid(rsp_valid), .rsp(rsp)
	);

endmodule

`default_nettype wire

// ==== hdl/motion_status.sv ====
// Motion status: tracks the active move, joins joint completion, builds the response
`default_nettype none
`timescale 1ns/1ps

`include "scara_defs.svh"

module motion_status (
	input  wire                       CLOCK_50,
	input  wire                       rst,
	input  logic                      move_strobe,
	input  logic                      stop_strobe,
	input  logic                      reject_strobe,
	input  logic                      busy1,
	input  logic                      busy2,
	input  logic [`SCARA_STEP_W-1:0]  steps1,
	input  logic [`SCARA_STEP_W-1:0]  steps2,
	output logic                      move_active,
	output logic                      rsp_valid,
	output scara_pkg::response_t      rsp
);

	logic                    stopped;
	logic [`SCARA_REJ_W-1:0] rej_cnt;
	logic                    finish;

	// Busy is valid from the cycle after move_strobe, when move_active is already set
	assign finish = move_active & ~busy1 & ~busy2;

	// ============================================================
	// Move tracking and reject count
	// ============================================================
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			move_active <= 1'b0;
			rsp_valid   <= 1'b0;
			stopped     <= 1'b0;
			rej_cnt     <= '0;
		end else begin
			rsp_valid <= finish;
			if (move_strobe) begin
				move_active <= 1'b1;
				stopped     <= 1'b0;
			end else if (finish) begin
				move_active <= 1'b0;
			end
			// Stop while idle is ignored
			if (stop_strobe && move_active)
				stopped <= 1'b1;
			// Counter cleared on report, a reject in that same cycle survives
			if (finish)
				rej_cnt <= reject_strobe ? `SCARA_REJ_W'(1) : '0;
			else if (reject_strobe && !(&rej_cnt))
				rej_cnt <= rej_cnt + 1'b1;
		end
	end

	// Response word
	always_ff @(posedge CLOCK_50) begin
		if (finish) begin
			rsp.status  <= stopped ? scara_pkg::ST_STOPPED : scara_pkg::ST_DONE;
			rsp.rejects <= rej_cnt;
			rsp.steps1  <= steps1;
			rsp.steps2  <= steps2;
			rsp.spare   <= '0;
		end
	end

	// One response per move
	a_rsp_single: assert property (
		@(posedge CLOCK_50) disable iff (rst)
		rsp_valid |=> !rsp_valid
	);

endmodule

`default_nettype wire

// ==== hdl/stepper_joint.sv ====
// Stepper joint: step pulse generator with step counter and abort
`default_nettype none
`timescale 1ns/1ps

`include "scara_defs.svh"

module stepper_joint (
	input  wire                           CLOCK_50,
	input  wire                           rst,
	input  logic                          load,
	input  logic                          abort,
	input  scara_pkg::joint_req_t         req,
	input  logic                          fast,
	output logic                          step,
	output logic                          dir,
	output logic                          busy,
	output logic [`SCARA_STEP_W-1:0]      steps_taken
);

	// Phase timer must hold the slow half period
	localparam int TMR_W = $clog2(`SCARA_HALF_SLOW + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_HIGH,
		S_LOW
	} state_e;

	state_e                   state;
	logic [`SCARA_STEP_W-1:0] remaining;
	logic [TMR_W-1:0]         timer;
	logic [TMR_W-1:0]         half_last;
	logic                     phase_end;

	// Last timer value of a half period, follows the speed switch live
	assign half_last = fast ? TMR_W'(`SCARA_HALF_FAST - 1) : TMR_W'(`SCARA_HALF_SLOW - 1);
	// >= so a speed change mid phase cannot overrun
	assign phase_end = (timer >= half_last);

	// ============================================================
	// Step sequencer
	// ============================================================
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state       <= S_IDLE;
			remaining   <= '0;
			timer       <= '0;
			dir         <= 1'b0;
			steps_taken <= '0;
		end else if (load) begin
			dir       <= req.dir;
			remaining <= req.steps;
			timer     <= '0;
			// Zero count never leaves idle
			if (req.steps != '0) begin
				state       <= S_HIGH;
				steps_taken <= `SCARA_STEP_W'(1);
			end else begin
				state       <= S_IDLE;
				steps_taken <= '0;
			end
		end else if (abort) begin
			// Drop out now, count so far is kept
			state <= S_IDLE;
			timer <= '0;
		end else begin
			case (state)
				S_HIGH: begin
					timer <= phase_end ? '0 : timer + 1'b1;
					if (phase_end)
						state <= S_LOW;
				end
				S_LOW: begin
					timer <= phase_end ? '0 : timer + 1'b1;
					if (phase_end) begin
						remaining <= remaining - 1'b1;
						if (remaining == `SCARA_STEP_W'(1)) begin
							state <= S_IDLE;
						end else begin
							// Next rising edge of step
							state       <= S_HIGH;
							steps_taken <= steps_taken + 1'b1;
						end
					end
				end
				default: timer <= '0;
			endcase
		end
	end

	// Outputs decoded from the registered state
	assign step = (state == S_HIGH);
	assign busy = (state != S_IDLE);

	a_step_in_move: assert property (
		@(posedge CLOCK_50) disable iff (rst)
		step |-> busy
	);

endmodule

`default_nettype wire

// ==== hdl/command_decoder.sv ====
// Host command decoder: unpacks words, rejects moves while busy, issues joint requests
`default_nettype none
`timescale 1ns/1ps

`include "scara_defs.svh"

module command_decoder (
	input  wire                    CLOCK_50,
	input  wire                    rst,
	input  logic                   cmd_valid,
	input  scara_pkg::command_t    cmd_word,
	input  logic                   move_active,
	output logic                   move_strobe,
	output logic                   stop_strobe,
	output logic                   reject_strobe,
	output scara_pkg::joint_req_t  req1,
	output scara_pkg::joint_req_t  req2
);

	// ============================================================
	// Opcode decode
	// ============================================================
	logic is_move;
	logic is_stop;

	always_comb begin
		is_move = 1'b0;
		is_stop = 1'b0;
		if (cmd_valid) begin
			case (cmd_word.op)
				scara_pkg::OP_MOVE: is_move = 1'b1;
				scara_pkg::OP_STOP: is_stop = 1'b1;
				// NOP and unknown codes fall through
				default: ;
			endcase
		end
	end

	// ============================================================
	// Strobes, one cycle after the host word
	// ============================================================
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			move_strobe   <= 1'b0;
			stop_strobe   <= 1'b0;
			reject_strobe <= 1'b0;
		end else begin
			// Accept only when no move is running
			move_strobe   <= is_move & ~move_active;
			reject_strobe <= is_move & move_active;
			// Stop goes out regardless; idle joints ignore it
			stop_strobe   <= is_stop;
		end
	end

	// Per-joint requests
	// Top field bit is direction, low byte is count, middle bits unused
	always_ff @(posedge CLOCK_50) begin
		if (is_move && !move_active) begin
			req1.dir   <= cmd_word.x[`SCARA_FIELD_W-1];
			req1.steps <= cmd_word.x[`SCARA_STEP_W-1:0];
			req2.dir   <= cmd_word.y[`SCARA_FIELD_W-1];
			req2.steps <= cmd_word.y[`SCARA_STEP_W-1:0];
		end
	end

	// Only one outcome per host word
	a_one_strobe: assert property (
		@(posedge CLOCK_50) disable iff (rst)
		$onehot0({move_strobe, stop_strobe, reject_strobe})
	);

endmodule

`default_nettype wire

// ==== hdl/scara_pkg.sv ====
// Opcode and status enums, command, joint request and response structs
`default_nettype none

`include "scara_defs.svh"

package scara_pkg;

	// ============================================================
	// Encodings
	// ============================================================
	// Host opcodes; anything else is ignored
	typedef enum logic [`SCARA_OP_W-1:0] {
		OP_NOP  = 4'd0,
		OP_MOVE = 4'd1,
		OP_STOP = 4'd2
	} opcode_e;

	// How a move ended
	typedef enum logic [`SCARA_STAT_W-1:0] {
		ST_DONE    = 2'd0,
		ST_STOPPED = 2'd1
	} status_e;

	// ============================================================
	// Grouped signals
	// ============================================================
	// Host word, opcode in the low nibble
	typedef struct packed {
		logic [`SCARA_FIELD_W-1:0] y;
		logic [`SCARA_FIELD_W-1:0] x;
		opcode_e                   op;
	} command_t;

	// One joint's share of a move
	typedef struct packed {
		logic                     dir;
		logic [`SCARA_STEP_W-1:0] steps;
	} joint_req_t;

	// Response word back to the host, spare bits held at zero
	typedef struct packed {
		status_e                  status;
		logic [`SCARA_REJ_W-1:0]  rejects;
		logic [`SCARA_STEP_W-1:0] steps2;
		logic [`SCARA_STEP_W-1:0] steps1;
		logic [`SCARA_WORD_W-`SCARA_STAT_W-`SCARA_REJ_W-2*`SCARA_STEP_W-1:0] spare;
	} response_t;

endpackage

`default_nettype wire

// ==== include/scara_defs.svh ====
// Field widths, step half-periods and response code width for the SCARA motion path
`ifndef SCARA_DEFS_SVH
`define SCARA_DEFS_SVH

// ============================================================
// Host word layout
// ============================================================
`define SCARA_WORD_W 32
`define SCARA_OP_W 4
// x and y argument fields
`define SCARA_FIELD_W 14

// ============================================================
// Joint and response sizing
// ============================================================
`define SCARA_STEP_W 8
`define SCARA_REJ_W 8
`define SCARA_STAT_W 2

// Clock cycles per half step period
// Short values suit simulation; raise them for a real motor at 50 MHz
`define SCARA_HALF_FAST 4
`define SCARA_HALF_SLOW 16

`endif
